// File: design/eth_wb_pkg.sv
package eth_wb_pkg;

  // bus side
  typedef logic [31:0] wb_data_t;
  typedef logic [15:0] wb_addr_t;
  typedef logic [3:0]  wb_sel_t;

  // memory side
  typedef logic [47:0] arp_entry_t;
  typedef logic [63:0] buf_word_t;
  typedef logic [7:0]  arp_addr_t;
  typedef logic [10:0] buf_addr_t;

  // network configuration
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;

  // tx size counts 64-bit words
  typedef logic [7:0]  tx_size_t;
  typedef logic [10:0] rx_size_t;

  // register index is address bits 9:2
  typedef logic [7:0]  reg_idx_t;

  typedef enum logic [2:0] {
    REGION_NONE,
    REGION_REG,
    REGION_ARP,
    REGION_TX,
    REGION_RX
  } region_e;

  // byte address map
  localparam wb_addr_t REGS_BASE = 16'h0000;
  localparam wb_addr_t REGS_HIGH = 16'h0FFF;
  localparam wb_addr_t ARP_BASE  = 16'h1000;
  localparam wb_addr_t ARP_HIGH  = 16'h3FFF;
  localparam wb_addr_t TX_BASE   = 16'h4000;
  localparam wb_addr_t TX_HIGH   = 16'h7FFF;
  localparam wb_addr_t RX_BASE   = 16'h8000;
  localparam wb_addr_t RX_HIGH   = 16'hBFFF;

  // register indices
  localparam reg_idx_t REG_CORE_TYPE = 8'h00;
  localparam reg_idx_t REG_MAX_BUF   = 8'h01;
  localparam reg_idx_t REG_WORD_LEN  = 8'h02;
  localparam reg_idx_t REG_MAC_HI    = 8'h03;
  localparam reg_idx_t REG_MAC_LO    = 8'h04;
  localparam reg_idx_t REG_IP        = 8'h05;
  localparam reg_idx_t REG_GATEWAY   = 8'h06;
  localparam reg_idx_t REG_NETMASK   = 8'h07;
  localparam reg_idx_t REG_TXRX_BUF  = 8'h0A;
  localparam reg_idx_t REG_ENABLE    = 8'h0B;
  localparam reg_idx_t REG_PORT      = 8'h0C;
  localparam reg_idx_t REG_ARP_SIZE  = 8'h11;

  // core identity
  localparam logic [7:0]  CORE_REV      = 8'd1;
  localparam logic [7:0]  CORE_TYPE_40G = 8'd4;
  localparam logic [15:0] WORD_BYTES    = 16'd8;
  localparam logic [15:0] MAX_BUF_BYTES = 16'd16384;
  localparam logic [31:0] ARP_ENTRIES   = 32'd256;

endpackage

// File: design/eth_bus_if.sv
`timescale 1ns/1ps

// held wishbone request, valid from start until ack
interface eth_bus_if;

  eth_wb_pkg::wb_addr_t adr;
  eth_wb_pkg::wb_data_t dat;
  eth_wb_pkg::wb_sel_t  sel;
  logic                 we;

  modport sink (
    input adr,
    input dat,
    input sel,
    input we
  );

endinterface

// File: design/eth_wb_ctrl.sv
`timescale 1ns/1ps

module eth_wb_ctrl (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  cyc_i,
  input  logic                  stb_i,
  eth_bus_if.sink               bus,
  output logic                  ack_o,
  output logic                  reg_wr_o,
  output logic                  arp_wr_o,
  output logic                  tx_wr_o,
  output eth_wb_pkg::region_e   rd_src_o
);

  eth_wb_pkg::region_e region;
  logic                wait_state;
  logic                start;
  logic                mem_write;

  function automatic logic in_range(input eth_wb_pkg::wb_addr_t adr,
                                    input eth_wb_pkg::wb_addr_t lo,
                                    input eth_wb_pkg::wb_addr_t hi);
    return (adr >= lo) && (adr <= hi);
  endfunction

  always_comb begin
    region = eth_wb_pkg::REGION_NONE;
    if (in_range(bus.adr, eth_wb_pkg::REGS_BASE, eth_wb_pkg::REGS_HIGH)) begin
      region = eth_wb_pkg::REGION_REG;
    end else if (in_range(bus.adr, eth_wb_pkg::ARP_BASE, eth_wb_pkg::ARP_HIGH)) begin
      region = eth_wb_pkg::REGION_ARP;
    end else if (in_range(bus.adr, eth_wb_pkg::TX_BASE, eth_wb_pkg::TX_HIGH)) begin
      region = eth_wb_pkg::REGION_TX;
    end else if (in_range(bus.adr, eth_wb_pkg::RX_BASE, eth_wb_pkg::RX_HIGH)) begin
      region = eth_wb_pkg::REGION_RX;
    end
  end

  // one wait cycle while a memory write reads back its word
  assign wait_state = arp_wr_o | tx_wr_o;

  assign start = cyc_i && stb_i && !ack_o && !wait_state;

  assign mem_write = start && bus.we &&
                     (region == eth_wb_pkg::REGION_ARP || region == eth_wb_pkg::REGION_TX);

  assign reg_wr_o = start && bus.we && (region == eth_wb_pkg::REGION_REG);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_o    <= 1'b0;
      arp_wr_o <= 1'b0;
      tx_wr_o  <= 1'b0;
      rd_src_o <= eth_wb_pkg::REGION_NONE;
    end else begin
      ack_o    <= (start && !mem_write) || wait_state;
      arp_wr_o <= start && bus.we && (region == eth_wb_pkg::REGION_ARP);
      tx_wr_o  <= start && bus.we && (region == eth_wb_pkg::REGION_TX);
      if (start) begin
        rd_src_o <= region;
      end
    end
  end

endmodule

// File: design/eth_cfg_regs.sv
`timescale 1ns/1ps

module eth_cfg_regs #(
  parameter eth_wb_pkg::mac_addr_t FABRIC_MAC     = 48'hffff_ffff_ffff,
  parameter eth_wb_pkg::ip_addr_t  FABRIC_IP      = 32'hffff_ffff,
  parameter logic [7:0]            FABRIC_GATEWAY = 8'd0,
  parameter eth_wb_pkg::ip_addr_t  FABRIC_NETMASK = 32'hffff_ff00,
  parameter logic [15:0]           FABRIC_PORT    = 16'hffff,
  parameter logic                  FABRIC_ENABLE  = 1'b0,
  parameter logic                  CPU_TX_ENABLE  = 1'b1,
  parameter logic                  CPU_RX_ENABLE  = 1'b1
) (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  eth_bus_if.sink               bus,
  input  logic                  wr_i,
  output eth_wb_pkg::wb_data_t  rd_data_o,
  output eth_wb_pkg::mac_addr_t local_mac_o,
  output eth_wb_pkg::ip_addr_t  local_ip_o,
  output logic [7:0]            local_gateway_o,
  output eth_wb_pkg::ip_addr_t  local_netmask_o,
  output logic [15:0]           local_port_o,
  output logic                  local_enable_o,
  output eth_wb_pkg::tx_size_t  tx_size_o,
  output logic                  tx_ready_o,
  input  logic                  tx_done_i,
  input  eth_wb_pkg::rx_size_t  rx_size_i,
  output logic                  rx_ack_o,
  output logic                  soft_reset_o,
  input  logic                  soft_reset_ack_i
);

  eth_wb_pkg::reg_idx_t reg_idx;
  eth_wb_pkg::wb_data_t mac_hi_wr;
  eth_wb_pkg::wb_data_t port_wr;
  eth_wb_pkg::rx_size_t rx_size_field;

  function automatic eth_wb_pkg::wb_data_t byte_merge(input eth_wb_pkg::wb_data_t cur,
                                                      input eth_wb_pkg::wb_data_t nxt,
                                                      input eth_wb_pkg::wb_sel_t  sel);
    eth_wb_pkg::wb_data_t res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = nxt[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign reg_idx = bus.adr[9:2];

  // 16-bit registers take only the two low lanes
  assign mac_hi_wr = byte_merge({16'b0, local_mac_o[47:32]}, bus.dat, bus.sel);
  assign port_wr   = byte_merge({16'b0, local_port_o}, bus.dat, bus.sel);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      local_mac_o     <= FABRIC_MAC;
      local_ip_o      <= FABRIC_IP;
      local_gateway_o <= FABRIC_GATEWAY;
      local_netmask_o <= FABRIC_NETMASK;
      local_port_o    <= FABRIC_PORT;
      local_enable_o  <= FABRIC_ENABLE;
      tx_size_o       <= '0;
      tx_ready_o      <= 1'b0;
      rx_ack_o        <= 1'b0;
      soft_reset_o    <= 1'b0;
    end else begin
      // core side clears, a host write in the same cycle wins
      if (tx_done_i) begin
        tx_size_o  <= '0;
        tx_ready_o <= 1'b0;
      end
      if (rx_size_i == '0) begin
        rx_ack_o <= 1'b0;
      end
      if (soft_reset_ack_i) begin
        soft_reset_o <= 1'b0;
      end

      if (wr_i) begin
        case (reg_idx)
          eth_wb_pkg::REG_MAC_HI: local_mac_o[47:32] <= mac_hi_wr[15:0];
          eth_wb_pkg::REG_MAC_LO: local_mac_o[31:0] <= byte_merge(local_mac_o[31:0],
                                                                  bus.dat, bus.sel);
          eth_wb_pkg::REG_IP:      local_ip_o <= byte_merge(local_ip_o, bus.dat, bus.sel);
          eth_wb_pkg::REG_NETMASK: local_netmask_o <= byte_merge(local_netmask_o,
                                                                 bus.dat, bus.sel);
          // gateway is a single byte
          eth_wb_pkg::REG_GATEWAY: begin
            if (bus.sel[0]) begin
              local_gateway_o <= bus.dat[7:0];
            end
          end
          eth_wb_pkg::REG_TXRX_BUF: begin
            if (bus.sel[0] && bus.dat[7:0] == 8'd0) begin
              rx_ack_o <= 1'b1;
            end
            if (bus.sel[2]) begin
              tx_size_o  <= bus.dat[23:16];
              tx_ready_o <= 1'b1;
            end
          end
          eth_wb_pkg::REG_ENABLE: begin
            if (bus.sel[0]) begin
              local_enable_o <= bus.dat[0];
            end
            if (bus.sel[2] && bus.dat[16]) begin
              soft_reset_o <= 1'b1;
            end
          end
          eth_wb_pkg::REG_PORT: local_port_o <= port_wr[15:0];
          default: ;
        endcase
      end
    end
  end

  // size hidden while the host still owns the acked buffer
  assign rx_size_field = rx_ack_o ? '0 : rx_size_i;

  always_comb begin
    case (reg_idx)
      eth_wb_pkg::REG_CORE_TYPE: rd_data_o = {7'b0, CPU_TX_ENABLE, 7'b0, CPU_RX_ENABLE,
                                              eth_wb_pkg::CORE_REV, eth_wb_pkg::CORE_TYPE_40G};
      eth_wb_pkg::REG_MAX_BUF:   rd_data_o = {eth_wb_pkg::MAX_BUF_BYTES,
                                              eth_wb_pkg::MAX_BUF_BYTES};
      eth_wb_pkg::REG_WORD_LEN:  rd_data_o = {eth_wb_pkg::WORD_BYTES, eth_wb_pkg::WORD_BYTES};
      eth_wb_pkg::REG_MAC_HI:    rd_data_o = {16'b0, local_mac_o[47:32]};
      eth_wb_pkg::REG_MAC_LO:    rd_data_o = local_mac_o[31:0];
      eth_wb_pkg::REG_IP:        rd_data_o = local_ip_o;
      eth_wb_pkg::REG_GATEWAY:   rd_data_o = {24'b0, local_gateway_o};
      eth_wb_pkg::REG_NETMASK:   rd_data_o = local_netmask_o;
      eth_wb_pkg::REG_TXRX_BUF:  rd_data_o = {8'b0, tx_size_o, 5'b0, rx_size_field};
      eth_wb_pkg::REG_ENABLE:    rd_data_o = {15'b0, soft_reset_o, 15'b0, local_enable_o};
      eth_wb_pkg::REG_PORT:      rd_data_o = {16'b0, local_port_o};
      eth_wb_pkg::REG_ARP_SIZE:  rd_data_o = eth_wb_pkg::ARP_ENTRIES;
      default:                   rd_data_o = '0;
    endcase
  end

endmodule

// File: design/eth_mem_port.sv
`timescale 1ns/1ps

module eth_mem_port #(
  parameter type word_t = eth_wb_pkg::buf_word_t,
  parameter type addr_t = eth_wb_pkg::buf_addr_t
) (
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  eth_bus_if.sink bus,
  input  logic    wr_i,
  input  word_t   rd_data_i,
  output addr_t   addr_o,
  output word_t   wr_data_o,
  output logic    wr_en_o
);

  localparam int WORD_BITS = $bits(word_t);
  localparam int ADDR_BITS = $bits(addr_t);
  localparam int NBYTES    = WORD_BITS / 8;

  word_t merged;

  // one 64-bit slot per word, bit 2 picks the half
  assign addr_o = bus.adr[ADDR_BITS+2:3];

  // bit 2 set addresses bits 31:0, clear addresses the bits above
  always_comb begin
    merged = rd_data_i;
    for (int b = 0; b < NBYTES; b++) begin
      if (((b >= 4) ? !bus.adr[2] : bus.adr[2]) && bus.sel[b % 4]) begin
        merged[8*b +: 8] = bus.dat[8*(b % 4) +: 8];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wr_i) begin
      wr_data_o <= merged;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_en_o <= 1'b0;
    end else begin
      wr_en_o <= wr_i;
    end
  end

endmodule

// File: design/eth_rd_mux.sv
`timescale 1ns/1ps

module eth_rd_mux (
  eth_bus_if.sink                bus,
  input  eth_wb_pkg::region_e    src_i,
  input  logic                   ack_i,
  input  eth_wb_pkg::wb_data_t   reg_data_i,
  input  eth_wb_pkg::arp_entry_t arp_data_i,
  input  eth_wb_pkg::buf_word_t  tx_data_i,
  input  eth_wb_pkg::buf_word_t  rx_data_i,
  output eth_wb_pkg::wb_data_t   dat_o
);

  eth_wb_pkg::wb_data_t arp_lane;
  eth_wb_pkg::wb_data_t tx_lane;
  eth_wb_pkg::wb_data_t rx_lane;
  eth_wb_pkg::wb_data_t sel_data;

  // upper arp half is only 16 bits wide
  assign arp_lane = bus.adr[2] ? arp_data_i[31:0] : {16'b0, arp_data_i[47:32]};
  assign tx_lane  = bus.adr[2] ? tx_data_i[31:0]  : tx_data_i[63:32];
  assign rx_lane  = bus.adr[2] ? rx_data_i[31:0]  : rx_data_i[63:32];

  always_comb begin
    case (src_i)
      eth_wb_pkg::REGION_REG: sel_data = reg_data_i;
      eth_wb_pkg::REGION_ARP: sel_data = arp_lane;
      eth_wb_pkg::REGION_TX:  sel_data = tx_lane;
      eth_wb_pkg::REGION_RX:  sel_data = rx_lane;
      default:                sel_data = '0;
    endcase
  end

  assign dat_o = ack_i ? sel_data : '0;

endmodule

// File: design/eth_wb_attach.sv
`timescale 1ns/1ps

module eth_wb_attach #(
  parameter eth_wb_pkg::mac_addr_t FABRIC_MAC     = 48'hffff_ffff_ffff,
  parameter eth_wb_pkg::ip_addr_t  FABRIC_IP      = 32'hffff_ffff,
  parameter logic [7:0]            FABRIC_GATEWAY = 8'd0,
  parameter eth_wb_pkg::ip_addr_t  FABRIC_NETMASK = 32'hffff_ff00,
  parameter logic [15:0]           FABRIC_PORT    = 16'hffff,
  parameter logic                  FABRIC_ENABLE  = 1'b0,
  parameter logic                  CPU_TX_ENABLE  = 1'b1,
  parameter logic                  CPU_RX_ENABLE  = 1'b1
) (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  eth_wb_pkg::wb_addr_t   wb_adr_i,
  input  eth_wb_pkg::wb_data_t   wb_dat_i,
  input  eth_wb_pkg::wb_sel_t    wb_sel_i,
  output eth_wb_pkg::wb_data_t   wb_dat_o,
  output logic                   wb_ack_o,
  // arp cache
  output eth_wb_pkg::arp_addr_t  arp_addr_o,
  output eth_wb_pkg::arp_entry_t arp_wr_data_o,
  output logic                   arp_wr_en_o,
  input  eth_wb_pkg::arp_entry_t arp_rd_data_i,
  // cpu tx buffer
  output eth_wb_pkg::buf_addr_t  tx_buf_addr_o,
  output eth_wb_pkg::buf_word_t  tx_buf_wr_data_o,
  output logic                   tx_buf_wr_en_o,
  input  eth_wb_pkg::buf_word_t  tx_buf_rd_data_i,
  // cpu rx buffer
  output eth_wb_pkg::buf_addr_t  rx_buf_addr_o,
  input  eth_wb_pkg::buf_word_t  rx_buf_rd_data_i,
  output eth_wb_pkg::mac_addr_t  local_mac_o,
  output eth_wb_pkg::ip_addr_t   local_ip_o,
  output logic [7:0]             local_gateway_o,
  output eth_wb_pkg::ip_addr_t   local_netmask_o,
  output logic [15:0]            local_port_o,
  output logic                   local_enable_o,
  output eth_wb_pkg::tx_size_t   tx_size_o,
  output logic                   tx_ready_o,
  input  logic                   tx_done_i,
  input  eth_wb_pkg::rx_size_t   rx_size_i,
  output logic                   rx_ack_o,
  output logic                   soft_reset_o,
  input  logic                   soft_reset_ack_i
);

  eth_bus_if bus ();

  logic                 reg_wr;
  logic                 arp_wr;
  logic                 tx_wr;
  eth_wb_pkg::region_e  rd_src;
  eth_wb_pkg::wb_data_t reg_rd_data;

  assign bus.adr = wb_adr_i;
  assign bus.dat = wb_dat_i;
  assign bus.sel = wb_sel_i;
  assign bus.we  = wb_we_i;

  // rx buffer is read only, so only an address is needed
  assign rx_buf_addr_o = wb_adr_i[13:3];

  eth_wb_ctrl u_ctrl (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .cyc_i    (wb_cyc_i),
    .stb_i    (wb_stb_i),
    .bus      (bus.sink),
    .ack_o    (wb_ack_o),
    .reg_wr_o (reg_wr),
    .arp_wr_o (arp_wr),
    .tx_wr_o  (tx_wr),
    .rd_src_o (rd_src)
  );

  eth_cfg_regs #(
    .FABRIC_MAC     (FABRIC_MAC),
    .FABRIC_IP      (FABRIC_IP),
    .FABRIC_GATEWAY (FABRIC_GATEWAY),
    .FABRIC_NETMASK (FABRIC_NETMASK),
    .FABRIC_PORT    (FABRIC_PORT),
    .FABRIC_ENABLE  (FABRIC_ENABLE),
    .CPU_TX_ENABLE  (CPU_TX_ENABLE),
    .CPU_RX_ENABLE  (CPU_RX_ENABLE)
  ) u_cfg_regs (
    .wb_clk_i         (wb_clk_i),
    .wb_rst_i         (wb_rst_i),
    .bus              (bus.sink),
    .wr_i             (reg_wr),
    .rd_data_o        (reg_rd_data),
    .local_mac_o      (local_mac_o),
    .local_ip_o       (local_ip_o),
    .local_gateway_o  (local_gateway_o),
    .local_netmask_o  (local_netmask_o),
    .local_port_o     (local_port_o),
    .local_enable_o   (local_enable_o),
    .tx_size_o        (tx_size_o),
    .tx_ready_o       (tx_ready_o),
    .tx_done_i        (tx_done_i),
    .rx_size_i        (rx_size_i),
    .rx_ack_o         (rx_ack_o),
    .soft_reset_o     (soft_reset_o),
    .soft_reset_ack_i (soft_reset_ack_i)
  );

  eth_mem_port #(
    .word_t (eth_wb_pkg::arp_entry_t),
    .addr_t (eth_wb_pkg::arp_addr_t)
  ) u_arp_port (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .bus       (bus.sink),
    .wr_i      (arp_wr),
    .rd_data_i (arp_rd_data_i),
    .addr_o    (arp_addr_o),
    .wr_data_o (arp_wr_data_o),
    .wr_en_o   (arp_wr_en_o)
  );

  eth_mem_port #(
    .word_t (eth_wb_pkg::buf_word_t),
    .addr_t (eth_wb_pkg::buf_addr_t)
  ) u_tx_port (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .bus       (bus.sink),
    .wr_i      (tx_wr),
    .rd_data_i (tx_buf_rd_data_i),
    .addr_o    (tx_buf_addr_o),
    .wr_data_o (tx_buf_wr_data_o),
    .wr_en_o   (tx_buf_wr_en_o)
  );

  eth_rd_mux u_rd_mux (
    .bus        (bus.sink),
    .src_i      (rd_src),
    .ack_i      (wb_ack_o),
    .reg_data_i (reg_rd_data),
    .arp_data_i (arp_rd_data_i),
    .tx_data_i  (tx_buf_rd_data_i),
    .rx_data_i  (rx_buf_rd_data_i),
    .dat_o      (wb_dat_o)
  );

endmodule

// File: sim/eth_mem_model.sv
`timescale 1ns/1ps

// synchronous-read memory, read data appears one cycle after the address
module eth_mem_model #(
  parameter type word_t = eth_wb_pkg::buf_word_t,
  parameter type addr_t = eth_wb_pkg::buf_addr_t
) (
  input  logic  clk_i,
  input  addr_t addr_i,
  input  logic  wr_en_i,
  input  word_t wr_data_i,
  output word_t rd_data_o
);

  localparam int DEPTH = 2 ** $bits(addr_t);

  // filled by the testbench before reset ends
  word_t mem [0:DEPTH-1];

  // read returns the old word on a same-edge write
  always @(posedge clk_i) begin
    rd_data_o <= mem[addr_i];
    if (wr_en_i) begin
      mem[addr_i] <= wr_data_i;
    end
  end

endmodule

// File: sim/tb_eth_wb_attach.sv
`timescale 1ns/1ps

module tb_eth_wb_attach;

  localparam eth_wb_pkg::mac_addr_t MAC_DEF  = 48'h0200_0a0b_0c0d;
  localparam eth_wb_pkg::ip_addr_t  IP_DEF   = 32'h0a00_0001;
  localparam logic [7:0]            GW_DEF   = 8'h01;
  localparam eth_wb_pkg::ip_addr_t  MASK_DEF = 32'hffff_ff00;
  localparam logic [15:0]           PORT_DEF = 16'h2710;
  localparam int                    RAND_N   = 16;

  typedef struct packed {
    logic                 is_write;
    eth_wb_pkg::wb_addr_t adr;
    eth_wb_pkg::wb_data_t dat;
    eth_wb_pkg::wb_sel_t  sel;
    eth_wb_pkg::wb_data_t exp;
    logic [1:0]           dly;
  } step_t;

  logic wb_clk_i;
  logic wb_rst_i;
  logic wb_cyc_i;
  logic wb_stb_i;
  logic wb_we_i;
  eth_wb_pkg::wb_addr_t   wb_adr_i;
  eth_wb_pkg::wb_data_t   wb_dat_i;
  eth_wb_pkg::wb_sel_t    wb_sel_i;
  eth_wb_pkg::wb_data_t   wb_dat_o;
  logic                   wb_ack_o;
  eth_wb_pkg::arp_addr_t  arp_addr;
  eth_wb_pkg::arp_entry_t arp_wr_data;
  logic                   arp_wr_en;
  eth_wb_pkg::arp_entry_t arp_rd_data;
  eth_wb_pkg::buf_addr_t  tx_addr;
  eth_wb_pkg::buf_word_t  tx_wr_data;
  logic                   tx_wr_en;
  eth_wb_pkg::buf_word_t  tx_rd_data;
  eth_wb_pkg::buf_addr_t  rx_addr;
  eth_wb_pkg::buf_word_t  rx_rd_data;
  eth_wb_pkg::mac_addr_t  local_mac;
  eth_wb_pkg::ip_addr_t   local_ip;
  logic [7:0]             local_gateway;
  eth_wb_pkg::ip_addr_t   local_netmask;
  logic [15:0]            local_port;
  logic                   local_enable;
  eth_wb_pkg::tx_size_t   tx_size;
  logic                   tx_ready;
  logic                   tx_done_i;
  eth_wb_pkg::rx_size_t   rx_size_i;
  logic                   rx_ack;
  logic                   soft_reset;
  logic                   soft_reset_ack_i;

  step_t                 steps[$];
  eth_wb_pkg::buf_word_t tx_ref [0:7];
  integer                seed;
  int                    cycles;
  int                    limit;

  eth_wb_attach #(
    .FABRIC_MAC (MAC_DEF), .FABRIC_IP (IP_DEF), .FABRIC_GATEWAY (GW_DEF),
    .FABRIC_NETMASK (MASK_DEF), .FABRIC_PORT (PORT_DEF), .FABRIC_ENABLE (1'b1),
    .CPU_TX_ENABLE (1'b1), .CPU_RX_ENABLE (1'b0)
  ) dut (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i), .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i), .wb_sel_i (wb_sel_i), .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .arp_addr_o (arp_addr), .arp_wr_data_o (arp_wr_data), .arp_wr_en_o (arp_wr_en),
    .arp_rd_data_i (arp_rd_data),
    .tx_buf_addr_o (tx_addr), .tx_buf_wr_data_o (tx_wr_data), .tx_buf_wr_en_o (tx_wr_en),
    .tx_buf_rd_data_i (tx_rd_data),
    .rx_buf_addr_o (rx_addr), .rx_buf_rd_data_i (rx_rd_data),
    .local_mac_o (local_mac), .local_ip_o (local_ip), .local_gateway_o (local_gateway),
    .local_netmask_o (local_netmask), .local_port_o (local_port),
    .local_enable_o (local_enable),
    .tx_size_o (tx_size), .tx_ready_o (tx_ready), .tx_done_i (tx_done_i),
    .rx_size_i (rx_size_i), .rx_ack_o (rx_ack),
    .soft_reset_o (soft_reset), .soft_reset_ack_i (soft_reset_ack_i)
  );

  eth_mem_model #(
    .word_t (eth_wb_pkg::arp_entry_t), .addr_t (eth_wb_pkg::arp_addr_t)
  ) arp_model (
    .clk_i (wb_clk_i), .addr_i (arp_addr), .wr_en_i (arp_wr_en),
    .wr_data_i (arp_wr_data), .rd_data_o (arp_rd_data)
  );

  eth_mem_model #(
    .word_t (eth_wb_pkg::buf_word_t), .addr_t (eth_wb_pkg::buf_addr_t)
  ) tx_model (
    .clk_i (wb_clk_i), .addr_i (tx_addr), .wr_en_i (tx_wr_en),
    .wr_data_i (tx_wr_data), .rd_data_o (tx_rd_data)
  );

  eth_mem_model #(
    .word_t (eth_wb_pkg::buf_word_t), .addr_t (eth_wb_pkg::buf_addr_t)
  ) rx_model (
    .clk_i (wb_clk_i), .addr_i (rx_addr), .wr_en_i (1'b0),
    .wr_data_i ('0), .rd_data_o (rx_rd_data)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #10 wb_clk_i = ~wb_clk_i;
  end

  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("run stopped: cycle limit reached before the tests completed");
      $display("Regression failed");
      $fatal(1);
    end
  end

  task automatic fail_now(input string msg);
    $display("ERROR @%0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input eth_wb_pkg::wb_data_t got,
                            input eth_wb_pkg::wb_data_t exp);
    if (got !== exp) begin
      fail_now($sformatf("%s got %08h expected %08h", what, got, exp));
    end
  endtask

  task automatic check_arp(input string what, input eth_wb_pkg::arp_entry_t got,
                           input eth_wb_pkg::arp_entry_t exp);
    if (got !== exp) begin
      fail_now($sformatf("%s got %012h expected %012h", what, got, exp));
    end
  endtask

  task automatic check_buf(input string what, input eth_wb_pkg::buf_word_t got,
                           input eth_wb_pkg::buf_word_t exp);
    if (got !== exp) begin
      fail_now($sformatf("%s got %016h expected %016h", what, got, exp));
    end
  endtask

  task automatic check_ack_delay(input eth_wb_pkg::wb_addr_t adr, input int got,
                                 input int exp);
    if (got != exp) begin
      fail_now($sformatf("ack delay at %04h got %0d expected %0d", adr, got, exp));
    end
  endtask

  // one transfer, entered and left 1 ns after a rising edge
  task automatic bus_cycle(input logic we, input eth_wb_pkg::wb_addr_t adr,
                           input eth_wb_pkg::wb_data_t dat, input eth_wb_pkg::wb_sel_t sel,
                           output eth_wb_pkg::wb_data_t rdat, output int dly);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    dly = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      dly++;
    end while (!wb_ack_o);
    rdat = wb_dat_o;
    // address stays put while a memory write lands
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(posedge wb_clk_i);
    #1;
  endtask

  task automatic wb_write(input eth_wb_pkg::wb_addr_t adr, input eth_wb_pkg::wb_data_t dat,
                          input eth_wb_pkg::wb_sel_t sel, input int exp_dly);
    eth_wb_pkg::wb_data_t unused;
    int dly;
    bus_cycle(1'b1, adr, dat, sel, unused, dly);
    check_ack_delay(adr, dly, exp_dly);
  endtask

  task automatic wb_read(input eth_wb_pkg::wb_addr_t adr, input eth_wb_pkg::wb_data_t exp,
                         input int exp_dly);
    eth_wb_pkg::wb_data_t rdat;
    int dly;
    bus_cycle(1'b0, adr, '0, 4'hf, rdat, dly);
    check_ack_delay(adr, dly, exp_dly);
    check_word($sformatf("read %04h", adr), rdat, exp);
  endtask

  task automatic add_step(input logic w, input eth_wb_pkg::wb_addr_t adr,
                          input eth_wb_pkg::wb_data_t dat, input eth_wb_pkg::wb_sel_t sel,
                          input eth_wb_pkg::wb_data_t exp, input logic [1:0] dly);
    steps.push_back('{w, adr, dat, sel, exp, dly});
  endtask

  task automatic cycle_wait(input int n);
    repeat (n) @(posedge wb_clk_i);
    #1;
  endtask

  task automatic build_table;
    // identity and reset values
    add_step(0, 16'h0000, 0, 0, 32'h0100_0104, 1);
    add_step(0, 16'h0004, 0, 0, 32'h4000_4000, 1);
    add_step(0, 16'h0008, 0, 0, 32'h0008_0008, 1);
    add_step(0, 16'h0044, 0, 0, 32'h0000_0100, 1);
    add_step(0, 16'h000C, 0, 0, 32'h0000_0200, 1);
    add_step(0, 16'h0010, 0, 0, 32'h0a0b_0c0d, 1);
    add_step(0, 16'h0028, 0, 0, 32'h0000_0040, 1);
    add_step(0, 16'h002C, 0, 0, 32'h0000_0001, 1);
    // partial byte selects
    add_step(1, 16'h0014, 32'hc0a8_0105, 4'b0011, 0, 1);
    add_step(0, 16'h0014, 0, 0, 32'h0a00_0105, 1);
    add_step(1, 16'h000C, 32'haaaa_1234, 4'b1111, 0, 1);
    add_step(0, 16'h000C, 0, 0, 32'h0000_1234, 1);
    add_step(1, 16'h0030, 32'h0000_5500, 4'b0010, 0, 1);
    add_step(0, 16'h0030, 0, 0, 32'h0000_5510, 1);
    add_step(1, 16'h0018, 32'h0000_00ee, 4'b0001, 0, 1);
    add_step(0, 16'h0018, 0, 0, 32'h0000_00ee, 1);
    add_step(1, 16'h0020, 32'hffff_ffff, 4'b1111, 0, 1);
    add_step(0, 16'h0020, 0, 0, 32'h0000_0000, 1);
    add_step(1, 16'hC000, 32'h1234_5678, 4'b1111, 0, 1);
    add_step(0, 16'hC000, 0, 0, 32'h0000_0000, 1);
    // arp merges by lane and half
    add_step(1, 16'h1004, 32'h1122_3344, 4'b1111, 0, 2);
    add_step(1, 16'h1000, 32'h5566_7788, 4'b0011, 0, 2);
    add_step(1, 16'h1004, 32'h00ab_0000, 4'b0100, 0, 2);
    add_step(0, 16'h1004, 0, 0, 32'h11ab_3344, 1);
    add_step(0, 16'h1000, 0, 0, 32'h0000_7788, 1);
    add_step(1, 16'h102C, 32'hdead_beef, 4'b1001, 0, 2);
    add_step(0, 16'h102C, 0, 0, 32'hde00_00ef, 1);
    // rx preload lanes
    add_step(0, 16'h801C, 0, 0, 32'h0303_0303, 1);
    add_step(0, 16'h8010, 0, 0, 32'h0202_0202, 1);
  endtask

  initial begin
    eth_wb_pkg::buf_word_t word;
    eth_wb_pkg::wb_data_t  rdat;
    eth_wb_pkg::wb_sel_t   sel;
    int idx;
    logic half;
    seed = 86891;
    cycles = 0;
    wb_rst_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    tx_done_i = 1'b0;
    rx_size_i = 11'h040;
    soft_reset_ack_i = 1'b0;
    build_table();
    limit = (steps.size() + 2 * RAND_N + 16) * 4 + 200;
    for (int i = 0; i < 256; i++) begin
      arp_model.mem[i] = '0;
    end
    for (int i = 0; i < 2048; i++) begin
      tx_model.mem[i] = '0;
      rx_model.mem[i] = 64'(i) * 64'h0101_0101_0101_0101;
    end
    for (int i = 0; i < 8; i++) begin
      tx_ref[i] = '0;
    end

    repeat (16) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;

    check_word("mac hi", {16'b0, local_mac[47:32]}, {16'b0, MAC_DEF[47:32]});
    check_word("mac lo", local_mac[31:0], MAC_DEF[31:0]);
    check_word("ip", local_ip, IP_DEF);
    check_word("gateway", {24'b0, local_gateway}, {24'b0, GW_DEF});
    check_word("netmask", local_netmask, MASK_DEF);
    check_word("port", {16'b0, local_port}, {16'b0, PORT_DEF});
    check_word("status", {28'b0, local_enable, tx_ready, rx_ack, soft_reset}, 32'h8);
    check_word("idle data", wb_dat_o, '0);

    foreach (steps[i]) begin
      if (steps[i].is_write) begin
        wb_write(steps[i].adr, steps[i].dat, steps[i].sel, steps[i].dly);
      end else begin
        wb_read(steps[i].adr, steps[i].exp, steps[i].dly);
      end
    end

    check_arp("arp entry 0", arp_model.mem[0], 48'h7788_11ab_3344);
    check_arp("arp entry 5", arp_model.mem[5], 48'h0000_de00_00ef);
    check_word("mac hi out", {16'b0, local_mac[47:32]}, 32'h0000_1234);
    check_word("mac lo out", local_mac[31:0], 32'h0a0b_0c0d);
    check_word("ip out", local_ip, 32'h0a00_0105);
    check_word("port out", {16'b0, local_port}, 32'h0000_5510);
    check_word("gateway out", {24'b0, local_gateway}, 32'h0000_00ee);

    // random tx merges against a reference of the first eight words
    for (int k = 0; k < RAND_N; k++) begin
      idx  = $random(seed) & 7;
      half = $random(seed);
      rdat = $random(seed);
      sel  = $random(seed);
      word = tx_ref[idx];
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          if (half) word[8*b +: 8] = rdat[8*b +: 8];
          else word[32 + 8*b +: 8] = rdat[8*b +: 8];
        end
      end
      tx_ref[idx] = word;
      wb_write(16'h4000 + 16'(idx * 8) + (half ? 16'h4 : 16'h0), rdat, sel, 2);
      check_buf($sformatf("tx word %0d", idx), tx_model.mem[idx], tx_ref[idx]);
      wb_read(16'h4000 + 16'(idx * 8) + (half ? 16'h4 : 16'h0),
              half ? tx_ref[idx][31:0] : tx_ref[idx][63:32], 1);
    end

    // tx handshake
    wb_write(16'h0028, 32'h0012_0000, 4'b0100, 1);
    check_word("tx size", {24'b0, tx_size}, 32'h12);
    check_word("tx ready", {31'b0, tx_ready}, 32'h1);
    wb_read(16'h0028, 32'h0012_0040, 1);
    tx_done_i = 1'b1;
    cycle_wait(1);
    tx_done_i = 1'b0;
    check_word("tx cleared", {23'b0, tx_ready, tx_size}, 32'h0);

    // rx acknowledge
    wb_write(16'h0028, 32'h0000_0000, 4'b0001, 1);
    check_word("rx ack", {31'b0, rx_ack}, 32'h1);
    wb_read(16'h0028, 32'h0000_0000, 1);
    rx_size_i = '0;
    cycle_wait(1);
    check_word("rx ack cleared", {31'b0, rx_ack}, 32'h0);
    rx_size_i = 11'h040;

    // soft reset holds until acknowledged
    wb_write(16'h002C, 32'h0001_0000, 4'b0100, 1);
    cycle_wait(5);
    check_word("soft reset held", {31'b0, soft_reset}, 32'h1);
    wb_read(16'h002C, 32'h0001_0001, 1);
    soft_reset_ack_i = 1'b1;
    cycle_wait(1);
    soft_reset_ack_i = 1'b0;
    check_word("soft reset cleared", {31'b0, soft_reset}, 32'h0);

    $display("Regression passed");
    $finish;
  end

endmodule

// File: list.f
design/eth_wb_pkg.sv
design/eth_bus_if.sv
design/eth_wb_ctrl.sv
design/eth_cfg_regs.sv
design/eth_mem_port.sv
design/eth_rd_mux.sv
design/eth_wb_attach.sv
sim/eth_mem_model.sv
sim/tb_eth_wb_attach.sv

// File: run.sh
#!/bin/bash
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wall -f list.f --top-module tb_eth_wb_attach -o sim_tb \
  > build.log 2>&1 && ./obj_dir/sim_tb > sim.log 2>&1 || echo "Regression failed" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
